//--- hw/wb_bus_pkg.sv
`default_nettype none

package wb_bus_pkg;

    localparam int WB_ADDR_W = 4;   // word address
    localparam int WB_DATA_W = 32;

    // register map, word addresses
    localparam logic [WB_ADDR_W-1:0] REG_CMD        = 4'd0;  // write only
    localparam logic [WB_ADDR_W-1:0] REG_STATUS     = 4'd1;  // read only
    localparam logic [WB_ADDR_W-1:0] REG_RDATA_BASE = 4'd2;  // channel n at base+n

endpackage

`default_nettype wire

//--- hw/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    // 24C16: 2 Kbyte, top three address bits ride in the control byte
    localparam int EE_ADDR_W = 11;
    localparam logic [3:0] EE_DEV_CODE = 4'b1010;

    // packing matches the low bits of the command word
    typedef struct packed {
        logic                 read;   // bit 19
        logic [EE_ADDR_W-1:0] addr;   // bits 18..8
        logic [7:0]           wdata;  // bits 7..0
    } cmd_t;

    // channel number starts right above the command
    localparam int CMD_W = $bits(cmd_t);

endpackage

`default_nettype wire

//--- hw/eeprom_chan_if.sv
`timescale 1ns/1ps
`default_nettype none

interface eeprom_chan_if;
    import eeprom_pkg::*;

    logic       req_valid;
    logic       req_ready;
    cmd_t       req_cmd;
    logic       done;   // one cycle, end of stop
    logic       nack;
    logic [7:0] rdata;

    modport regs (output req_valid, output req_cmd, input req_ready);

    modport master (input req_valid, input req_cmd,
                    output req_ready, output done, output nack, output rdata);

    modport status (input req_valid, input req_ready, input done, input nack, input rdata);

endinterface

`default_nettype wire

//--- hw/wb_eeprom_regs.sv
`timescale 1ns/1ps
`default_nettype none

module wb_eeprom_regs #(
    parameter int NUM_CHANNELS = 2,
    localparam int SEL_W = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1
) (
    input  logic                             CLK,
    input  logic                             RESET,
    input  logic                             wb_cyc,
    input  logic                             wb_stb,
    input  logic                             wb_we,
    input  logic [wb_bus_pkg::WB_ADDR_W-1:0] wb_adr,
    input  logic [wb_bus_pkg::WB_DATA_W-1:0] wb_dat_w,
    output logic [wb_bus_pkg::WB_DATA_W-1:0] wb_dat_r,
    output logic                             wb_ack,
    input  logic [wb_bus_pkg::WB_DATA_W-1:0] status_word,
    input  logic [wb_bus_pkg::WB_DATA_W-1:0] rdata_word,
    output logic [SEL_W-1:0]                 rdata_sel,
    eeprom_chan_if.regs                      chan [0:NUM_CHANNELS-1]
);
    import wb_bus_pkg::*;
    import eeprom_pkg::*;

    localparam int CHAN_W = WB_DATA_W - CMD_W;

    logic                    pend_valid;
    logic [SEL_W-1:0]        pend_ch;
    cmd_t                    pend_cmd;
    logic [NUM_CHANNELS-1:0] ready_vec;
    logic                    req_new;
    logic                    xfer;
    logic [CHAN_W-1:0]       cmd_ch;
    logic [WB_ADDR_W-1:0]    rd_idx;
    logic                    rd_valid;

    // new bus cycle, not yet answered and nothing in flight
    assign req_new  = wb_cyc && wb_stb && !wb_ack && !pend_valid;
    assign cmd_ch   = wb_dat_w[WB_DATA_W-1:CMD_W];
    assign xfer     = pend_valid && ready_vec[pend_ch];
    assign rd_idx   = wb_adr - REG_RDATA_BASE;
    assign rd_valid = (wb_adr >= REG_RDATA_BASE) && (rd_idx < NUM_CHANNELS);
    assign rdata_sel = rd_idx[SEL_W-1:0];

    for (genvar i = 0; i < NUM_CHANNELS; i++)
    begin : g_chan
        assign chan[i].req_valid = pend_valid && (pend_ch == SEL_W'(i));
        assign chan[i].req_cmd   = pend_cmd;
        assign ready_vec[i]      = chan[i].req_ready;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wb_ack     <= 1'b0;
            pend_valid <= 1'b0;
        end
        else
        begin
            wb_ack <= 1'b0;
            if (xfer)
            begin
                pend_valid <= 1'b0;
                wb_ack     <= 1'b1;   // ack follows the handoff
            end
            else if (req_new)
            begin
                if (wb_we && wb_adr == REG_CMD && cmd_ch < NUM_CHANNELS)
                    pend_valid <= 1'b1;
                else
                    wb_ack <= 1'b1;   // reads, other writes, unknown channel
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (req_new && wb_we && wb_adr == REG_CMD)
        begin
            pend_ch  <= cmd_ch[SEL_W-1:0];
            pend_cmd <= cmd_t'(wb_dat_w[CMD_W-1:0]);
        end
        if (req_new && !wb_we)
        begin
            if (wb_adr == REG_STATUS)
                wb_dat_r <= status_word;
            else if (rd_valid)
                wb_dat_r <= rdata_word;
            else
                wb_dat_r <= '0;
        end
    end

    // host must hold the strobe until it sees ack
    ack_in_cycle: assert property (@(posedge CLK) disable iff (RESET)
        wb_ack |-> (wb_cyc && wb_stb));

    ack_single: assert property (@(posedge CLK) disable iff (RESET)
        wb_ack |=> !wb_ack);

    req_held: assert property (@(posedge CLK) disable iff (RESET)
        (pend_valid && !xfer) |=> (pend_valid && $stable(pend_ch) && $stable(pend_cmd)));

endmodule

`default_nettype wire

//--- hw/i2c_eeprom_master.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_eeprom_master #(
    parameter int CLK_DIV = 4
) (
    input  logic          CLK,
    input  logic          RESET,
    output logic          scl,
    output logic          sda_oe,
    input  logic          sda_in,
    eeprom_chan_if.master chan
);
    import eeprom_pkg::*;

    localparam int DIV_W = $clog2(CLK_DIV + 1);

    localparam logic [3:0] PH_IDLE    = 4'd0;
    localparam logic [3:0] PH_START   = 4'd1;
    localparam logic [3:0] PH_CTRL_WR = 4'd2;
    localparam logic [3:0] PH_ADDR    = 4'd3;
    localparam logic [3:0] PH_DATA_WR = 4'd4;
    localparam logic [3:0] PH_RSTART  = 4'd5;
    localparam logic [3:0] PH_CTRL_RD = 4'd6;
    localparam logic [3:0] PH_DATA_RD = 4'd7;
    localparam logic [3:0] PH_ACK     = 4'd8;
    localparam logic [3:0] PH_STOP    = 4'd9;

    logic [3:0]       phase;
    logic [3:0]       ph_next;
    logic [3:0]       after_ack;   // where to go once the ack bit is done
    logic [DIV_W-1:0] div_cnt;
    logic             tick;
    logic [1:0]       q;           // quarter of the scl period
    logic [2:0]       bit_cnt;
    logic [7:0]       sreg;
    logic [7:0]       rdata_q;
    cmd_t             cmd_q;
    logic             nack_q;
    logic             byte_ph;
    logic             master_ack;

    assign tick = (div_cnt == DIV_W'(CLK_DIV - 1));
    assign byte_ph = (phase == PH_CTRL_WR) || (phase == PH_ADDR) || (phase == PH_DATA_WR) ||
                     (phase == PH_CTRL_RD) || (phase == PH_DATA_RD);
    // the ack slot after the read byte is ours (not-acknowledge)
    assign master_ack = cmd_q.read && (after_ack == PH_STOP);

    assign chan.req_ready = (phase == PH_IDLE);
    assign chan.done      = (phase == PH_STOP) && tick && (q == 2'd3);
    assign chan.nack      = nack_q;
    assign chan.rdata     = rdata_q;

    function automatic logic [7:0] byte_for(input logic [3:0] ph);
        case (ph)
            PH_CTRL_WR: return {EE_DEV_CODE, cmd_q.addr[EE_ADDR_W-1:8], 1'b0};
            PH_ADDR:    return cmd_q.addr[7:0];
            PH_DATA_WR: return cmd_q.wdata;
            PH_CTRL_RD: return {EE_DEV_CODE, cmd_q.addr[EE_ADDR_W-1:8], 1'b1};
            default:    return 8'hff;   // all ones keeps sda released
        endcase
    endfunction

    always_comb
    begin
        ph_next = phase;
        case (phase)
            PH_START:  ph_next = PH_CTRL_WR;
            PH_RSTART: ph_next = PH_CTRL_RD;
            PH_ACK:    ph_next = nack_q ? PH_STOP : after_ack;
            PH_STOP:   ph_next = PH_IDLE;
            default:
            begin
                if (byte_ph && bit_cnt == 3'd7)
                    ph_next = PH_ACK;
            end
        endcase
    end

    // q0 scl falls, q1 sda moves, q2 scl rises and samples, q3 start/stop edge
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            phase     <= PH_IDLE;
            after_ack <= PH_STOP;
            div_cnt   <= '0;
            q         <= 2'd0;
            bit_cnt   <= 3'd0;
            scl       <= 1'b1;
            sda_oe    <= 1'b0;
            nack_q    <= 1'b0;
        end
        else if (phase == PH_IDLE)
        begin
            div_cnt <= '0;
            q       <= 2'd0;
            bit_cnt <= 3'd0;
            if (chan.req_valid)
            begin
                phase  <= PH_START;
                nack_q <= 1'b0;
            end
        end
        else
        begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
            if (tick)
            begin
                q <= q + 2'd1;
                case (q)
                    2'd0: scl <= 1'b0;
                    2'd1:
                    begin
                        case (phase)
                            PH_START, PH_RSTART, PH_ACK: sda_oe <= 1'b0;
                            PH_STOP: sda_oe <= 1'b1;
                            default: sda_oe <= ~sreg[7];
                        endcase
                    end
                    2'd2:
                    begin
                        scl <= 1'b1;
                        if (phase == PH_ACK && !master_ack && sda_in)
                            nack_q <= 1'b1;   // slave left sda high
                    end
                    default:
                    begin
                        phase <= ph_next;
                        if (phase == PH_START || phase == PH_RSTART)
                            sda_oe <= 1'b1;
                        if (phase == PH_STOP)
                            sda_oe <= 1'b0;
                        if (byte_ph)
                            bit_cnt <= bit_cnt + 3'd1;   // wraps after bit 0
                        if (byte_ph && bit_cnt == 3'd7)
                        begin
                            case (phase)
                                PH_CTRL_WR: after_ack <= PH_ADDR;
                                PH_ADDR:    after_ack <= cmd_q.read ? PH_RSTART : PH_DATA_WR;
                                PH_CTRL_RD: after_ack <= PH_DATA_RD;
                                default:    after_ack <= PH_STOP;
                            endcase
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (chan.req_valid && chan.req_ready)
            cmd_q <= chan.req_cmd;
        if (tick && q == 2'd2 && byte_ph)
            sreg <= {sreg[6:0], sda_in};   // shifts out and in at once
        if (tick && q == 2'd3)
        begin
            if (phase == PH_START || phase == PH_RSTART || phase == PH_ACK)
                sreg <= byte_for(ph_next);
            // held across writes, so status always sees the last byte read
            if (phase == PH_DATA_RD && bit_cnt == 3'd7)
                rdata_q <= sreg;
        end
    end

    sda_quiet_scl_high: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && $changed(sda_oe)) |->
        ($past(phase) == PH_START || $past(phase) == PH_RSTART || $past(phase) == PH_STOP));

endmodule

`default_nettype wire

//--- hw/eeprom_status.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_status #(
    parameter int NUM_CHANNELS = 2,
    localparam int SEL_W = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1
) (
    input  logic                             CLK,
    input  logic                             RESET,
    eeprom_chan_if.status                    chan [0:NUM_CHANNELS-1],
    input  logic [SEL_W-1:0]                 rdata_sel,
    output logic [wb_bus_pkg::WB_DATA_W-1:0] status_word,
    output logic [wb_bus_pkg::WB_DATA_W-1:0] rdata_word
);
    import wb_bus_pkg::*;

    logic [NUM_CHANNELS-1:0] take;
    logic [NUM_CHANNELS-1:0] fin;
    logic [NUM_CHANNELS-1:0] fin_nack;
    logic [NUM_CHANNELS-1:0] busy;
    logic [NUM_CHANNELS-1:0] nack_f;
    logic [7:0]              rd_in [NUM_CHANNELS];
    logic [7:0]              rd_byte [NUM_CHANNELS];

    for (genvar i = 0; i < NUM_CHANNELS; i++)
    begin : g_chan
        assign take[i]     = chan[i].req_valid && chan[i].req_ready;
        assign fin[i]      = chan[i].done;
        assign fin_nack[i] = chan[i].nack;
        assign rd_in[i]    = chan[i].rdata;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy   <= '0;
            nack_f <= '0;
        end
        else
        begin
            for (int i = 0; i < NUM_CHANNELS; i++)
            begin
                if (take[i])
                begin
                    busy[i]   <= 1'b1;
                    nack_f[i] <= 1'b0;   // sticky until the next command
                end
                else if (fin[i])
                begin
                    busy[i] <= 1'b0;
                    if (fin_nack[i])
                        nack_f[i] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        for (int i = 0; i < NUM_CHANNELS; i++)
        begin
            if (fin[i])
                rd_byte[i] <= rd_in[i];
        end
    end

    assign status_word = {{(WB_DATA_W-16){1'b0}}, 8'(nack_f), 8'(busy)};
    assign rdata_word  = {{(WB_DATA_W-8){1'b0}}, rd_byte[rdata_sel]};

endmodule

`default_nettype wire

//--- hw/eeprom_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_ctrl_top #(
    parameter int NUM_CHANNELS = 2,
    parameter int CLK_DIV = 4,   // clk cycles per quarter scl
    localparam int SEL_W = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1
) (
    input  logic                             CLK,
    input  logic                             RESET,
    input  logic                             wb_cyc,
    input  logic                             wb_stb,
    input  logic                             wb_we,
    input  logic [wb_bus_pkg::WB_ADDR_W-1:0] wb_adr,
    input  logic [wb_bus_pkg::WB_DATA_W-1:0] wb_dat_w,
    output logic [wb_bus_pkg::WB_DATA_W-1:0] wb_dat_r,
    output logic                             wb_ack,
    output logic [NUM_CHANNELS-1:0]          scl,
    output logic [NUM_CHANNELS-1:0]          sda_oe,
    input  logic [NUM_CHANNELS-1:0]          sda_in
);
    import wb_bus_pkg::*;

    logic [WB_DATA_W-1:0] status_word;
    logic [WB_DATA_W-1:0] rdata_word;
    logic [SEL_W-1:0]     rdata_sel;

    eeprom_chan_if chan_if [0:NUM_CHANNELS-1] ();

    wb_eeprom_regs #(.NUM_CHANNELS(NUM_CHANNELS)) i_regs (
        .CLK         (CLK),
        .RESET       (RESET),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .status_word (status_word),
        .rdata_word  (rdata_word),
        .rdata_sel   (rdata_sel),
        .chan        (chan_if)
    );

    for (genvar g = 0; g < NUM_CHANNELS; g++)
    begin : g_master
        i2c_eeprom_master #(.CLK_DIV(CLK_DIV)) i_master (
            .CLK    (CLK),
            .RESET  (RESET),
            .scl    (scl[g]),
            .sda_oe (sda_oe[g]),
            .sda_in (sda_in[g]),
            .chan   (chan_if[g])
        );
    end

    eeprom_status #(.NUM_CHANNELS(NUM_CHANNELS)) i_status (
        .CLK         (CLK),
        .RESET       (RESET),
        .chan        (chan_if),
        .rdata_sel   (rdata_sel),
        .status_word (status_word),
        .rdata_word  (rdata_word)
    );

endmodule

`default_nettype wire

//--- sim/eeprom_model.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_model (
    input  logic       RESET,
    input  logic       scl,
    input  logic       sda_oe,   // master pulls low
    output logic       sda,      // resolved open-drain line
    output logic [2:0] err       // first protocol violation, 0 when clean
);
    localparam logic [2:0] ST_IDLE = 3'd0;
    localparam logic [2:0] ST_CTRL = 3'd1;
    localparam logic [2:0] ST_ADDR = 3'd2;
    localparam logic [2:0] ST_DATA = 3'd3;
    localparam logic [2:0] ST_READ = 3'd4;

    logic [7:0]  mem [2048];
    logic [2:0]  state;
    logic [2:0]  next_state;
    logic        pull;
    logic        first;      // falling scl right after a start is not a bit
    logic [7:0]  sh;
    logic [7:0]  rbyte;
    logic [10:0] addr;
    int          cnt;

    assign sda = !(sda_oe || pull);

    initial
    begin
        for (int a = 0; a < 2048; a++)
            mem[a] = 8'(a) ^ {a[10:8], 5'h15};
        state = ST_IDLE;
        next_state = ST_IDLE;
        pull = 1'b0;
        first = 1'b0;
        cnt = 0;
        addr = '0;
        err = 3'd0;
    end

    // start: sda falls with scl high
    always @(negedge sda)
    begin
        if (!RESET && scl === 1'b1)
        begin
            if (cnt != 0 && err == 0)
                err = 3'd1;
            state = ST_CTRL;
            cnt = 0;
            first = 1'b1;
            pull = 1'b0;
        end
    end

    // stop: sda rises with scl high
    always @(posedge sda)
    begin
        if (!RESET && scl === 1'b1)
        begin
            if (cnt != 0 && err == 0)
                err = 3'd1;
            state = ST_IDLE;
            cnt = 0;
            pull = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (!RESET && state != ST_IDLE && !first)
        begin
            if (state != ST_READ && cnt < 8)
                sh = {sh[6:0], sda};
            if (state == ST_READ && cnt == 8 && sda == 1'b0 && err == 0)
                err = 3'd4;   // master should not-acknowledge the single byte
        end
    end

    always @(negedge scl)
    begin
        if (!RESET && state != ST_IDLE)
        begin
            if (first)
                first = 1'b0;
            else if (cnt == 8)
            begin
                pull = 1'b0;   // end of ack slot
                cnt = 0;
                state = next_state;
                if (state == ST_READ)
                    pull = !rbyte[7];
            end
            else
            begin
                cnt = cnt + 1;
                if (state == ST_READ)
                begin
                    pull = (cnt < 8) ? !rbyte[7-cnt] : 1'b0;
                    if (cnt == 8)
                        next_state = ST_IDLE;   // single byte only
                end
                else if (cnt == 8)
                begin
                    pull = 1'b1;   // ack
                    case (state)
                        ST_CTRL:
                        begin
                            if (sh[7:4] != 4'b1010)
                            begin
                                if (err == 0)
                                    err = 3'd2;
                                pull = 1'b0;
                                next_state = ST_IDLE;
                            end
                            else if (!sh[0])
                            begin
                                addr[10:8] = sh[3:1];
                                next_state = ST_ADDR;
                            end
                            else
                            begin
                                if (sh[3:1] != addr[10:8] && err == 0)
                                    err = 3'd3;
                                rbyte = mem[addr];
                                next_state = ST_READ;
                            end
                        end
                        ST_ADDR:
                        begin
                            addr[7:0] = sh;
                            next_state = ST_DATA;
                        end
                        default:
                        begin
                            mem[addr] = sh;
                            next_state = ST_DATA;
                        end
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_eeprom_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_eeprom_ctrl;
    import wb_bus_pkg::*;

    localparam int NUM_CH  = 3;
    localparam int DIV     = 4;
    localparam int NUM_TXN = 40;
    localparam int SCL_CYC = 4 * DIV;
    localparam longint WATCHDOG_NS = longint'(NUM_TXN) * 40 * SCL_CYC * 20 + 20000;

    logic                 CLK;
    logic                 RESET;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    logic [WB_ADDR_W-1:0] wb_adr;
    logic [WB_DATA_W-1:0] wb_dat_w;
    logic [WB_DATA_W-1:0] wb_dat_r;
    logic                 wb_ack;
    logic [NUM_CH-1:0]    scl;
    logic [NUM_CH-1:0]    sda_oe;
    logic [NUM_CH-1:0]    sda_in;
    logic                 sda0;
    logic                 sda1;
    logic [2:0]           err0;
    logic [2:0]           err1;

    logic [7:0]  shadow [2][2048];
    logic [31:0] rng;
    int unsigned cycles;
    logic [10:0] addrs [$];

    eeprom_ctrl_top #(.NUM_CHANNELS(NUM_CH), .CLK_DIV(DIV)) i_dut (
        .CLK(CLK), .RESET(RESET),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .scl(scl), .sda_oe(sda_oe), .sda_in(sda_in)
    );

    eeprom_model i_ee0 (.RESET(RESET), .scl(scl[0]), .sda_oe(sda_oe[0]), .sda(sda0), .err(err0));
    eeprom_model i_ee1 (.RESET(RESET), .scl(scl[1]), .sda_oe(sda_oe[1]), .sda(sda1), .err(err1));

    assign sda_in = {1'b1, sda1, sda0};   // channel 2 has no device

    initial
    begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    always @(posedge CLK)
        cycles <= cycles + 1;

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired, a transaction never finished");
        $display("sim failed");
        $fatal(1);
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic string model_err_text(input logic [2:0] code);
        case (code)
            3'd1: return "start or stop in the middle of a byte";
            3'd2: return "control byte without device code 1010";
            3'd3: return "read control byte with wrong high address bits";
            3'd4: return "master acknowledged the read byte";
            default: return "unknown bus error";
        endcase
    endfunction

    model_clean: assert property (@(posedge CLK) disable iff (RESET) (err0 == 0 && err1 == 0))
        else
        begin
            $display("bus protocol error: %s", model_err_text(err0 != 0 ? err0 : err1));
            $display("sim failed");
            $fatal(1);
        end

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (exp == got)
            else
            begin
                $display("Mismatch %s expected %0h actual %0h", name, exp, got);
                $display("sim failed");
                $fatal(1);
            end
    endtask

    task automatic wb_write(input logic [WB_ADDR_W-1:0] adr, input logic [WB_DATA_W-1:0] dat);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = 1'b1;
        wb_adr = adr;
        wb_dat_w = dat;
        do
            @(negedge CLK);
        while (!wb_ack);
        @(negedge CLK);   // ack is sampled on the edge in between
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    task automatic wb_read(input logic [WB_ADDR_W-1:0] adr, output logic [WB_DATA_W-1:0] dat);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = 1'b0;
        wb_adr = adr;
        do
            @(negedge CLK);
        while (!wb_ack);
        dat = wb_dat_r;
        @(negedge CLK);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic send_cmd(input int ch, input logic rd, input logic [10:0] a,
                            input logic [7:0] d);
        wb_write(REG_CMD, (WB_DATA_W'(ch) << 20) | (WB_DATA_W'(rd) << 19) |
                          (WB_DATA_W'(a) << 8) | WB_DATA_W'(d));
    endtask

    task automatic wait_idle(input int ch);
        logic [WB_DATA_W-1:0] st;
        do
            wb_read(REG_STATUS, st);
        while (st[ch]);
    endtask

    task automatic ee_write(input int ch, input logic [10:0] a, input logic [7:0] d);
        send_cmd(ch, 1'b0, a, d);
        wait_idle(ch);
        shadow[ch][a] = d;
    endtask

    task automatic ee_read_check(input int ch, input logic [10:0] a, input string name);
        logic [WB_DATA_W-1:0] got;
        logic [WB_DATA_W-1:0] st;
        send_cmd(ch, 1'b1, a, 8'h00);
        wait_idle(ch);
        wb_read(REG_RDATA_BASE + WB_ADDR_W'(ch), got);
        check_eq(name, 32'(shadow[ch][a]), got);
        wb_read(REG_STATUS, st);
        check_eq({name, "_nack"}, 32'd0, 32'(st[8+ch]));
    endtask

    initial
    begin
        logic [WB_DATA_W-1:0] st;
        logic [10:0]          a;
        logic [7:0]           d;
        int unsigned          t0;
        RESET = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        cycles = 0;
        rng = 32'd18946;
        repeat (10) @(negedge CLK);
        RESET = 1'b0;

        @(negedge CLK);
        check_eq("reset_scl", 32'h7, 32'(scl));
        check_eq("reset_sda_oe", 32'h0, 32'(sda_oe));
        wb_read(REG_STATUS, st);
        check_eq("reset_status", 32'h0, st);

        // random writes across all control-byte blocks, then read back
        for (int i = 0; i < 8; i++)
        begin
            rng = xorshift(rng);
            a = {3'(i), rng[7:0]};
            ee_write(0, a, rng[15:8]);
            addrs.push_back(a);
        end
        foreach (addrs[i])
            ee_read_check(0, addrs[i], "rand_read_ch0");

        // two channels at once, same addresses, own data
        for (int i = 0; i < 3; i++)
        begin
            rng = xorshift(rng);
            a = rng[10:0];
            send_cmd(0, 1'b0, a, rng[23:16]);
            send_cmd(1, 1'b0, a, rng[31:24]);
            wb_read(REG_STATUS, st);
            check_eq("both_busy", 32'h3, 32'(st[1:0]));
            wait_idle(0);
            wait_idle(1);
            shadow[0][a] = rng[23:16];
            shadow[1][a] = rng[31:24];
            ee_read_check(0, a, "indep_ch0");
            ee_read_check(1, a, "indep_ch1");
        end

        // second command waits for the first to finish
        rng = xorshift(rng);
        a = rng[10:0];
        d = rng[18:11];
        send_cmd(0, 1'b0, a, d);
        t0 = cycles;
        send_cmd(0, 1'b0, a ^ 11'h400, ~d);
        assert (cycles - t0 >= 29 * SCL_CYC - 8)
            else
            begin
                $display("second command acknowledged while channel 0 was still busy");
                $display("sim failed");
                $fatal(1);
            end
        wb_read(REG_STATUS, st);
        check_eq("backpressure_busy", 32'h1, 32'(st[0]));
        wait_idle(0);
        shadow[0][a] = d;
        shadow[0][a ^ 11'h400] = ~d;
        ee_read_check(0, a, "backpressure_first");
        ee_read_check(0, a ^ 11'h400, "backpressure_second");

        // empty bus on channel 2
        send_cmd(2, 1'b0, 11'h123, 8'h5a);
        wb_read(REG_STATUS, st);
        check_eq("nodev_busy", 32'h1, 32'(st[2]));
        wait_idle(2);
        wb_read(REG_STATUS, st);
        check_eq("nodev_nack", 32'h1, 32'(st[10]));
        ee_write(0, 11'h7ff, 8'hc3);
        ee_read_check(0, 11'h7ff, "after_nodev_ch0");

        // channel number out of range is dropped
        send_cmd(3, 1'b0, 11'h0, 8'h0);
        wb_read(REG_STATUS, st);
        check_eq("bad_channel_busy", 32'h0, 32'(st[7:0]));

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
hw/wb_bus_pkg.sv
hw/eeprom_pkg.sv
hw/eeprom_chan_if.sv
hw/wb_eeprom_regs.sv
hw/i2c_eeprom_master.sv
hw/eeprom_status.sv
hw/eeprom_ctrl_top.sv
sim/eeprom_model.sv
sim/tb_eeprom_ctrl.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_eeprom_ctrl -f all.f \
    --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
rc=$?
cat sim.log
if [ $rc -ne 0 ]; then
    echo "simulation exited with status $rc"
    exit 1
fi

if grep -q "^sim passed$" sim.log; then
    exit 0
fi
exit 1
